// File: Bender.yml
package:
  name: cart_loader

sources:
  - design/cart_pkg.sv
  - design/backup_pkg.sv
  - design/load_stream_if.sv
  - design/download_decoder.sv
  - design/rom_header_parser.sv
  - design/cheat_code_assembler.sv
  - design/backup_sequencer.sv
  - design/cart_loader_top.sv
  - target: simulation
    files:
      - test/tb_cart_loader.sv

// File: design/backup_pkg.sv
/* Backup RAM sector sequencer definitions: sector size, sector number
   width and the transfer states */
package backup_pkg;

	// 512-byte sectors
	localparam int SECTOR_SHIFT = 9;

	// Save RAM mask bits above one sector
	localparam int LBA_W = cart_pkg::MASK_W - SECTOR_SHIFT;

	typedef enum logic [1:0] {
		BK_IDLE     = 2'd0,
		BK_REQUEST  = 2'd1,
		BK_TRANSFER = 2'd2
	} bk_state_t;

endpackage

// File: design/backup_sequencer.sv
/* Loads and saves backup RAM one 512-byte sector at a time through the
   image host, with an automatic load after each cartridge download */
module backup_sequencer import cart_pkg::*, backup_pkg::*; (
	input  logic              clk_sys,
	input  logic              RESET,
	load_stream_if.code_sink  stream,
	input  logic [MASK_W-1:0] ram_mask,
	input  logic              img_mounted,
	input  logic              img_readonly,
	input  logic [63:0]       img_size,
	input  logic              load_req,
	input  logic              save_req,
	input  logic              sd_ack,
	output logic [LBA_W-1:0]  sd_lba,
	output logic              sd_rd,
	output logic              sd_wr,
	output logic              bk_busy,
	output logic              core_hold
);

	bk_state_t        state;
	logic             bk_ena;
	logic             bk_loading;
	logic             load_q;
	logic             load_qq;
	logic             save_q;
	logic             save_qq;
	logic             ack_q;
	logic             ack_rise;
	logic             ack_fall;
	logic             start_load;
	logic             start_save;
	logic [LBA_W-1:0] last_lba;

	assign last_lba   = ram_mask[MASK_W-1:SECTOR_SHIFT];
	assign ack_rise   = sd_ack & ~ack_q;
	assign ack_fall   = ~sd_ack & ack_q;
	// Auto load wins over a user request in the same cycle
	assign start_load = (stream.cart_end & (|img_size) & bk_ena) |
		(bk_ena & load_q & ~load_qq);
	assign start_save = bk_ena & save_q & ~save_qq & ~start_load;

	assign bk_busy   = (state != BK_IDLE);
	assign core_hold = RESET | stream.cart_active | bk_loading;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			load_q  <= 1'b0;
			load_qq <= 1'b0;
			save_q  <= 1'b0;
			save_qq <= 1'b0;
			ack_q   <= 1'b0;
			bk_ena  <= 1'b0;
		end else begin
			load_q  <= load_req;
			load_qq <= load_q;
			save_q  <= save_req;
			save_qq <= save_q;
			ack_q   <= sd_ack;
			if (stream.cart_start) begin
				bk_ena <= 1'b0;
			end
			// Save image is mounted while the cartridge loads
			if (stream.cart_active && img_mounted && !img_readonly) begin
				bk_ena <= |ram_mask;
			end
		end
	end

	// ======================================================================
	// Sector FSM
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state      <= BK_IDLE;
			bk_loading <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
		end else begin
			case (state)
				BK_IDLE: begin
					if (start_load || start_save) begin
						state      <= BK_REQUEST;
						bk_loading <= start_load;
						sd_lba     <= '0;
						sd_rd      <= start_load;
						sd_wr      <= start_save;
					end
				end
				BK_REQUEST: begin
					if (ack_rise) begin
						state <= BK_TRANSFER;
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
					end
				end
				BK_TRANSFER: begin
					// Host releases ack once the sector is moved
					if (ack_fall) begin
						if (sd_lba >= last_lba) begin
							state      <= BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							state  <= BK_REQUEST;
							sd_lba <= sd_lba + LBA_W'(1);
							sd_rd  <= bk_loading;
							sd_wr  <= ~bk_loading;
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

	assert property (@(posedge clk_sys) disable iff (RESET) !(sd_rd && sd_wr))
		else $error("sector read and write requested together");

	assert property (@(posedge clk_sys) disable iff (RESET)
		(state == BK_IDLE) |-> !(sd_rd || sd_wr))
		else $error("sector request raised while idle");

endmodule

// File: design/cart_loader_top.sv
/* Cartridge loading path: download decoding, header parsing, cheat code
   assembly and backup RAM sequencing, with plain ports toward the host */
module cart_loader_top import cart_pkg::*, backup_pkg::*; (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              dl_active,
	input  logic [7:0]        dl_index,
	input  logic              dl_wr,
	input  logic [ADDR_W-1:0] dl_addr,
	input  logic [WORD_W-1:0] dl_data,
	input  hdr_mode_t         hdr_mode,
	input  region_sel_t       region_sel,
	input  logic              img_mounted,
	input  logic              img_readonly,
	input  logic [63:0]       img_size,
	input  logic              load_req,
	input  logic              save_req,
	input  logic              sd_ack,
	output rom_type_t         rom_type,
	output logic [MASK_W-1:0] rom_mask,
	output logic [MASK_W-1:0] ram_mask,
	output logic              pal,
	output logic [CODE_W-1:0] code,
	output logic              code_valid,
	output logic              code_clear,
	output logic [LBA_W-1:0]  sd_lba,
	output logic              sd_rd,
	output logic              sd_wr,
	output logic              bk_busy,
	output logic              core_hold
);

	load_stream_if stream ();

	download_decoder u_decoder (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.dl_active (dl_active),
		.dl_index  (dl_index),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.stream    (stream.source)
	);

	rom_header_parser u_parser (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.hdr_mode   (hdr_mode),
		.region_sel (region_sel),
		.stream     (stream.header_sink),
		.rom_type   (rom_type),
		.rom_mask   (rom_mask),
		.ram_mask   (ram_mask),
		.pal        (pal)
	);

	cheat_code_assembler u_cheats (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.stream     (stream.code_sink),
		.code       (code),
		.code_valid (code_valid),
		.code_clear (code_clear)
	);

	// Save RAM size comes from the parsed header
	backup_sequencer u_backup (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.stream       (stream.code_sink),
		.ram_mask     (ram_mask),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.load_req     (load_req),
		.save_req     (save_req),
		.sd_ack       (sd_ack),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_busy      (bk_busy),
		.core_hold    (core_hold)
	);

endmodule

// File: design/cart_pkg.sv
/* Cartridge loading definitions: stream widths, ROM header locations,
   header and region option encodings, cheat code size */
package cart_pkg;

	localparam int ADDR_W = 25;
	localparam int WORD_W = 16;
	localparam int MASK_W = 24;
	localparam int CODE_W = 128;

	// Host stream index that carries cheat files
	localparam logic [7:0] CODE_INDEX = 8'hFF;

	// ======================================================================
	// ROM header
	// ======================================================================

	// Copier header placed in front of the image
	localparam logic [ADDR_W-1:0] HDR_COPIER_OFS = 25'h000200;

	// Size word of the internal header, RAM size follows 2 bytes later
	localparam logic [ADDR_W-1:0] HDR_LO_ADDR   = 25'h007FD6 + HDR_COPIER_OFS;
	localparam logic [ADDR_W-1:0] HDR_HI_ADDR   = 25'h00FFD6 + HDR_COPIER_OFS;
	localparam logic [ADDR_W-1:0] HDR_EXHI_ADDR = 25'h40FFD6 + HDR_COPIER_OFS;

	localparam logic [3:0] DEFAULT_ROM_SIZE = 4'hC;

	typedef enum logic [2:0] {
		HDR_AUTO    = 3'd0,
		HDR_NONE    = 3'd1,
		HDR_LOROM   = 3'd2,
		HDR_HIROM   = 3'd3,
		HDR_EXHIROM = 3'd4
	} hdr_mode_t;

	typedef enum logic [1:0] {
		REGION_AUTO = 2'd0,
		REGION_NTSC = 2'd1,
		REGION_PAL  = 2'd2
	} region_sel_t;

	// Mapper codes seen by the console core
	typedef enum logic [7:0] {
		ROM_LO   = 8'h00,
		ROM_HI   = 8'h01,
		ROM_EXHI = 8'h02
	} rom_type_t;

endpackage

// File: design/cheat_code_assembler.sv
/* Collects eight cheat stream words into one replace code and marks
   it valid on the last word; also flags when the code list restarts */
module cheat_code_assembler import cart_pkg::*; (
	input  logic              clk_sys,
	input  logic              RESET,
	load_stream_if.code_sink  stream,
	output logic [CODE_W-1:0] code,
	output logic              code_valid,
	output logic              code_clear
);

	logic [2:0] word_idx;
	logic [6:0] word_lsb;
	logic       word_wr;
	logic       last_word;

	// Layout {flags, address, compare, replace}, 32 bits each, big-endian
	// values with the bottom word first in the file
	assign word_idx  = stream.addr[3:1];
	assign word_lsb  = {~word_idx[2:1], word_idx[0], 4'b0000};
	assign word_wr   = stream.code_wr & ~stream.addr[0];
	assign last_word = (stream.addr[3:0] == 4'd14);

	always_ff @(posedge clk_sys) begin
		if (word_wr) begin
			code[word_lsb +: WORD_W] <= stream.data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_valid <= 1'b0;
			code_clear <= 1'b0;
		end else begin
			code_valid <= word_wr & last_word;
			// New cartridge or a cheat file from its first byte
			code_clear <= stream.cart_start | (stream.code_wr & (stream.addr == '0));
		end
	end

	// Codes are 16 bytes apart, so completions never run back to back
	assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid |=> !code_valid)
		else $error("code_valid held for two cycles");

endmodule

// File: design/download_decoder.sv
/* Registers the host download stream and splits it into cartridge and
   cheat traffic, with start and end pulses for a cartridge download */
module download_decoder import cart_pkg::*; (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              dl_active,
	input  logic [7:0]        dl_index,
	input  logic              dl_wr,
	input  logic [ADDR_W-1:0] dl_addr,
	input  logic [WORD_W-1:0] dl_data,
	load_stream_if.source     stream
);

	logic is_code;
	logic cart_dl;

	assign is_code = (dl_index == CODE_INDEX);
	assign cart_dl = dl_active & ~is_code;

	// Strobes and download level, cart_active doubles as the previous level
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			stream.cart_wr     <= 1'b0;
			stream.code_wr     <= 1'b0;
			stream.cart_active <= 1'b0;
			stream.cart_start  <= 1'b0;
			stream.cart_end    <= 1'b0;
		end else begin
			stream.cart_wr     <= dl_wr & cart_dl;
			stream.code_wr     <= dl_wr & dl_active & is_code;
			stream.cart_active <= cart_dl;
			stream.cart_start  <= cart_dl & ~stream.cart_active;
			stream.cart_end    <= ~cart_dl & stream.cart_active;
		end
	end

	// Word payload, held between writes
	always_ff @(posedge clk_sys) begin
		if (dl_wr) begin
			stream.addr <= dl_addr;
			stream.data <= dl_data;
		end
	end

	// A word goes to exactly one consumer
	assert property (@(posedge clk_sys) disable iff (RESET)
		!(stream.cart_wr && stream.code_wr))
		else $error("cartridge and cheat strobes high together");

endmodule

// File: design/load_stream_if.sv
/* Decoded download stream, driven by the download decoder and read by
   the header parser, the cheat assembler and the backup sequencer */
interface load_stream_if import cart_pkg::*; ();

	// Word strobes, one cycle each
	logic              cart_wr;
	logic              code_wr;
	logic [ADDR_W-1:0] addr;
	logic [WORD_W-1:0] data;

	// Cartridge download level and its edges
	logic              cart_active;
	logic              cart_start;
	logic              cart_end;

	modport source (
		output cart_wr, code_wr, addr, data, cart_active, cart_start, cart_end
	);

	modport header_sink (
		input cart_wr, addr, data, cart_active
	);

	modport code_sink (
		input code_wr, addr, data, cart_active, cart_start, cart_end
	);

endinterface

// File: design/rom_header_parser.sv
/* Reads the cartridge stream for mapper type, ROM and save RAM sizes
   and region, and turns the sizes into address masks for the core */
module rom_header_parser import cart_pkg::*; (
	input  logic               clk_sys,
	input  logic               RESET,
	input  hdr_mode_t          hdr_mode,
	input  region_sel_t        region_sel,
	load_stream_if.header_sink stream,
	output rom_type_t          rom_type,
	output logic [MASK_W-1:0]  rom_mask,
	output logic [MASK_W-1:0]  ram_mask,
	output logic               pal
);

	logic [3:0]        rom_size;
	logic [3:0]        ram_size;
	logic              rom_region;
	logic              hdr_used;
	logic [ADDR_W-1:0] size_addr;

	// Size code n covers 1 KiB << n
	function automatic logic [MASK_W-1:0] size_to_mask(input logic [3:0] size);
		return (MASK_W'(1024) << size) - MASK_W'(1);
	endfunction

	// Internal header location for the forced mapper modes
	always_comb begin
		hdr_used  = 1'b1;
		size_addr = HDR_LO_ADDR;
		case (hdr_mode)
			HDR_HIROM:   size_addr = HDR_HI_ADDR;
			HDR_EXHIROM: size_addr = HDR_EXHI_ADDR;
			HDR_LOROM:   size_addr = HDR_LO_ADDR;
			default:     hdr_used  = 1'b0;
		endcase
	end

	// ======================================================================
	// Header fields
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= DEFAULT_ROM_SIZE;
			ram_size   <= 4'h0;
			rom_type   <= ROM_LO;
			rom_region <= 1'b0;
		end else if (stream.cart_wr) begin
			if (stream.addr == '0) begin
				rom_size <= DEFAULT_ROM_SIZE;
				ram_size <= 4'h0;
				// Loader prefix word: {type, ram size, rom size}
				if (hdr_mode == HDR_AUTO && stream.data[7:0] != 8'h00) begin
					{ram_size, rom_size} <= stream.data[7:0];
				end
				case (hdr_mode)
					HDR_AUTO:    rom_type <= rom_type_t'(stream.data[15:8]);
					HDR_HIROM:   rom_type <= ROM_HI;
					HDR_EXHIROM: rom_type <= ROM_EXHI;
					default:     rom_type <= ROM_LO;
				endcase
			end

			if (stream.addr == ADDR_W'(2)) begin
				rom_region <= stream.data[8];
			end

			if (hdr_used) begin
				if (stream.addr == size_addr) begin
					rom_size <= stream.data[11:8];
				end
				if (stream.addr == size_addr + ADDR_W'(2)) begin
					ram_size <= stream.data[3:0];
				end
			end
		end
	end

	// Masks trail the size registers by one cycle
	always_ff @(posedge clk_sys) begin
		rom_mask <= size_to_mask(rom_size);
		ram_mask <= (ram_size != 4'h0) ? size_to_mask(ram_size) : '0;
	end

	// Region is only switched outside a download
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			pal <= 1'b0;
		end else if (!stream.cart_active) begin
			if (region_sel == REGION_AUTO) begin
				pal <= rom_region;
			end else begin
				pal <= (region_sel == REGION_PAL);
			end
		end
	end

endmodule

// File: tb.f
design/cart_pkg.sv
design/backup_pkg.sv
design/load_stream_if.sv
design/download_decoder.sv
design/rom_header_parser.sv
design/cheat_code_assembler.sv
design/backup_sequencer.sv
design/cart_loader_top.sv
test/tb_cart_loader.sv

// File: test/tb_cart_loader.sv
/* Testbench for the cartridge loading path: drives downloads and cheat files,
   answers backup sector requests and compares outputs with reference values */
module tb_cart_loader import cart_pkg::*, backup_pkg::*; ();

	// Several times the longest test, which takes a few hundred cycles
	localparam int MAX_CYCLES = 20000;

	logic              clk_sys;
	logic              RESET;
	logic              dl_active;
	logic [7:0]        dl_index;
	logic              dl_wr;
	logic [ADDR_W-1:0] dl_addr;
	logic [WORD_W-1:0] dl_data;
	hdr_mode_t         hdr_mode;
	region_sel_t       region_sel;
	logic              img_mounted;
	logic              img_readonly;
	logic [63:0]       img_size;
	logic              load_req;
	logic              save_req;
	logic              sd_ack;
	rom_type_t         rom_type;
	logic [MASK_W-1:0] rom_mask;
	logic [MASK_W-1:0] ram_mask;
	logic              pal;
	logic [CODE_W-1:0] code;
	logic              code_valid;
	logic              code_clear;
	logic [LBA_W-1:0]  sd_lba;
	logic              sd_rd;
	logic              sd_wr;
	logic              bk_busy;
	logic              core_hold;

	integer            seed = 32'h02cd_5cc2;
	int                cycles = 0;
	int                hold_left = 0;
	int                valid_count = 0;
	int                clear_count = 0;
	logic [LBA_W-1:0]  lba_q[$];
	bit                op_q[$];

	// Expected header results compared every cycle while armed
	bit                hdr_armed = 1'b0;
	logic [7:0]        exp_type;
	logic [MASK_W-1:0] exp_rom;
	logic [MASK_W-1:0] exp_ram;
	logic              exp_pal;
	logic [CODE_W-1:0] exp_code;

	cart_loader_top dut0 (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.dl_active    (dl_active),
		.dl_index     (dl_index),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.hdr_mode     (hdr_mode),
		.region_sel   (region_sel),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.load_req     (load_req),
		.save_req     (save_req),
		.sd_ack       (sd_ack),
		.rom_type     (rom_type),
		.rom_mask     (rom_mask),
		.ram_mask     (ram_mask),
		.pal          (pal),
		.code         (code),
		.code_valid   (code_valid),
		.code_clear   (code_clear),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_busy      (bk_busy),
		.core_hold    (core_hold)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED: %s got %h expected %h", name, got, exp);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic fail_run(input string reason);
		$display("Error: %s", reason);
		$display("Test FAILED");
		$fatal(1);
	endtask

	function automatic logic [15:0] rand_word();
		return 16'($random(seed));
	endfunction

	// ======================================================================
	// Reference models
	// ======================================================================

	// Returns {type, rom mask, ram mask, pal}
	function automatic logic [56:0] header_ref(input hdr_mode_t mode,
		input region_sel_t rsel, input logic [15:0] w0, input logic [15:0] w2,
		input logic [15:0] wsz, input logic [15:0] wram);
		logic [3:0]  rs;
		logic [3:0]  ms;
		logic [7:0]  ty;
		logic [23:0] rm;
		logic [23:0] am;
		logic        p;
		rs = DEFAULT_ROM_SIZE;
		ms = 4'h0;
		case (mode)
			HDR_AUTO:    ty = w0[15:8];
			HDR_HIROM:   ty = 8'h01;
			HDR_EXHIROM: ty = 8'h02;
			default:     ty = 8'h00;
		endcase
		if (mode == HDR_AUTO && w0[7:0] != 8'h00) begin
			rs = w0[3:0];
			ms = w0[7:4];
		end
		if (mode == HDR_LOROM || mode == HDR_HIROM || mode == HDR_EXHIROM) begin
			rs = wsz[11:8];
			ms = wram[3:0];
		end
		rm = (24'd1024 << rs) - 24'd1;
		am = (ms == 4'h0) ? 24'd0 : (24'd1024 << ms) - 24'd1;
		p  = (rsel == REGION_AUTO) ? w2[8] : (rsel == REGION_PAL);
		return {ty, rm, am, p};
	endfunction

	// Field f of four 32-bit fields from the top, two words each, low word first
	function automatic logic [127:0] cheat_ref(input logic [7:0][15:0] w);
		logic [127:0] c;
		for (int f = 0; f < 4; f++) begin
			c[127 - 32*f -: 32] = {w[2*f+1], w[2*f]};
		end
		return c;
	endfunction

	// ======================================================================
	// Image host, comparator and watchdog
	// ======================================================================

	always @(posedge clk_sys) begin
		if (RESET) begin
			sd_ack    <= 1'b0;
			hold_left = 0;
		end else if (hold_left != 0) begin
			hold_left = hold_left - 1;
			if (hold_left == 0)
				sd_ack <= 1'b0;
		end else if (!sd_ack && (sd_rd || sd_wr)) begin
			lba_q.push_back(sd_lba);
			op_q.push_back(sd_wr);
			// Core must stay halted while backup RAM is loaded
			if (sd_rd)
				check_value("core_hold", core_hold, 1'b1);
			sd_ack    <= 1'b1;
			hold_left = 1 + ({$random(seed)} % 4);
		end
	end

	always @(posedge clk_sys) begin
		if (!RESET) begin
			if (code_valid) begin
				check_value("code", code, exp_code);
				valid_count = valid_count + 1;
			end
			if (code_clear)
				clear_count = clear_count + 1;
			if (hdr_armed) begin
				check_value("rom_type", rom_type, exp_type);
				check_value("rom_mask", rom_mask, exp_rom);
				check_value("ram_mask", ram_mask, exp_ram);
				check_value("pal", pal, exp_pal);
			end
		end
	end

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Error: run timed out after %0d cycles", cycles);
			$display("Test FAILED");
			$fatal(1);
		end
	end

	// ======================================================================
	// Stimulus tasks
	// ======================================================================

	task automatic write_word(input logic [ADDR_W-1:0] a, input logic [WORD_W-1:0] d);
		dl_addr <= a;
		dl_data <= d;
		dl_wr   <= 1'b1;
		@(posedge clk_sys);
	endtask

	// Gap lets the masks settle before the download level drops
	task automatic finish_download();
		dl_wr <= 1'b0;
		repeat (4) @(posedge clk_sys);
		dl_active <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic run_header(input hdr_mode_t mode, input region_sel_t rsel,
		input logic [15:0] w0, input logic [15:0] w2, input logic [15:0] wsz,
		input logic [15:0] wram);
		logic [ADDR_W-1:0] sa;
		sa = (mode == HDR_HIROM) ? HDR_HI_ADDR :
			(mode == HDR_EXHIROM) ? HDR_EXHI_ADDR : HDR_LO_ADDR;
		hdr_armed = 1'b0;
		hdr_mode   <= mode;
		region_sel <= rsel;
		dl_index   <= 8'h00;
		dl_active  <= 1'b1;
		@(posedge clk_sys);
		write_word('0, w0);
		write_word(ADDR_W'(2), w2);
		write_word(sa, wsz);
		write_word(sa + ADDR_W'(2), wram);
		finish_download();
		{exp_type, exp_rom, exp_ram, exp_pal} = header_ref(mode, rsel, w0, w2, wsz, wram);
		hdr_armed = 1'b1;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic run_cheats();
		logic [7:0][15:0] w;
		int               clr0;
		int               val0;
		int               n;
		clr0 = clear_count;
		val0 = valid_count;
		for (int i = 0; i < 8; i++)
			w[i] = rand_word();
		exp_code = cheat_ref(w);
		dl_index  <= CODE_INDEX;
		dl_active <= 1'b1;
		@(posedge clk_sys);
		for (int i = 0; i < 8; i++)
			write_word(ADDR_W'(2*i), w[i]);
		dl_wr <= 1'b0;
		n = 0;
		while (valid_count == val0 && n < 10) begin
			@(posedge clk_sys);
			n++;
		end
		if (valid_count == val0)
			fail_run("no code_valid pulse after eight cheat words");
		dl_active <= 1'b0;
		repeat (4) @(posedge clk_sys);
		check_value("code_valid pulses", valid_count - val0, 1);
		check_value("code_clear pulses", clear_count - clr0, 1);
	endtask

	task automatic pulse_request(input bit is_save);
		if (is_save)
			save_req <= 1'b1;
		else
			load_req <= 1'b1;
		@(posedge clk_sys);
		save_req <= 1'b0;
		load_req <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic expect_sectors(input bit is_write, input int count);
		while (lba_q.size() < count)
			@(posedge clk_sys);
		while (bk_busy)
			@(posedge clk_sys);
		// Core runs again once the transfer is over
		check_value("core_hold", core_hold, 1'b0);
		check_value("sector count", lba_q.size(), count);
		for (int i = 0; i < count; i++) begin
			check_value("sd_lba", lba_q[i], i);
			check_value("sd_wr", op_q[i], is_write);
		end
		lba_q.delete();
		op_q.delete();
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		int clr0;
		int sectors;
		RESET        = 1'b1;
		dl_active    = 1'b0;
		dl_index     = 8'h00;
		dl_wr        = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		hdr_mode     = HDR_AUTO;
		region_sel   = REGION_AUTO;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size     = 64'h0;
		load_req     = 1'b0;
		save_req     = 1'b0;
		sd_ack       = 1'b0;
		repeat (10) @(posedge clk_sys);
		RESET <= 1'b0;
		repeat (2) @(posedge clk_sys);

		// Auto and headerless modes, then a zero size byte
		for (int i = 0; i < 4; i++)
			run_header(HDR_AUTO, REGION_AUTO, rand_word(), rand_word(), rand_word(), rand_word());
		run_header(HDR_AUTO, REGION_AUTO, {8'(rand_word()), 8'h00}, rand_word(),
			rand_word(), rand_word());
		run_header(HDR_NONE, REGION_NTSC, rand_word(), rand_word(), rand_word(), rand_word());

		// Forced mapper modes and forced regions
		run_header(HDR_LOROM, REGION_PAL, rand_word(), rand_word(), rand_word(), rand_word());
		run_header(HDR_HIROM, REGION_NTSC, rand_word(), rand_word(), rand_word(), rand_word());
		run_header(HDR_EXHIROM, REGION_AUTO, rand_word(), rand_word(), rand_word(),
			rand_word());

		// Cheat file, then a cartridge start clears the code list
		run_cheats();
		clr0 = clear_count;
		run_header(HDR_AUTO, REGION_AUTO, rand_word(), rand_word(), rand_word(), rand_word());
		check_value("code_clear pulses", clear_count - clr0, 1);

		// Automatic load with a writable image
		img_mounted  <= 1'b1;
		img_readonly <= 1'b0;
		img_size     <= 64'h2000;
		run_header(HDR_LOROM, REGION_AUTO, rand_word(), rand_word(), rand_word(),
			{12'(rand_word() >> 4), 4'(1 + ({$random(seed)} % 3))});
		sectors = int'(exp_ram >> SECTOR_SHIFT) + 1;
		expect_sectors(1'b0, sectors);

		// Save of the same RAM
		pulse_request(1'b1);
		expect_sectors(1'b1, sectors);

		// Read-only image gives no traffic at all
		img_readonly <= 1'b1;
		run_header(HDR_LOROM, REGION_AUTO, rand_word(), rand_word(), rand_word(), 16'h0002);
		pulse_request(1'b1);
		pulse_request(1'b0);
		repeat (20) @(posedge clk_sys);
		check_value("requests with read-only image", lba_q.size(), 0);
		check_value("bk_busy", bk_busy, 1'b0);

		// No save RAM in the header
		img_readonly <= 1'b0;
		run_header(HDR_LOROM, REGION_AUTO, rand_word(), rand_word(), rand_word(), 16'h0000);
		pulse_request(1'b1);
		pulse_request(1'b0);
		repeat (20) @(posedge clk_sys);
		check_value("requests without save RAM", lba_q.size(), 0);
		check_value("bk_busy", bk_busy, 1'b0);

		$display("Test OK");
		$finish;
	end

endmodule
